// ==== common/replay_pkg.sv ====
//******************************
// shared widths and payload types for the miss replay buffer
// imported by every RTL module of the block
//******************************
package replay_pkg;

  // pipeline lanes sharing one queue slot
  localparam int LANES = 2;

  // virtual address and translation geometry
  localparam int VADDR_W = 44;
  localparam int PAGE_SHIFT = 14;
  localparam int PAGE_W = 30;

  // payload field widths
  localparam int SZ_W = 5;
  localparam int ATTR_W = 4;
  localparam int LSQ_W = 9;
  localparam int WQ_W = 6;

  // one memory operation as carried by a lane, 69 bits
  typedef struct packed {
    logic thread;
    logic [VADDR_W-1:0] addr;
    logic [SZ_W-1:0] sz;
    logic [ATTR_W-1:0] attr;
    logic [LSQ_W-1:0] lsq;
    logic [WQ_W-1:0] wq;
  } mem_op_t;

  // what one lane stores per queue slot
  typedef struct packed {
    logic miss;
    mem_op_t op;
  } queue_entry_t;

  // request on the shared translation port
  typedef struct packed {
    logic [PAGE_W-1:0] page;
    logic [ATTR_W-1:0] attr;
  } xlat_req_t;

endpackage

// ==== miss_queue/miss_queue_ram.sv ====
//******************************
// storage for one lane of the miss queue
// read address is registered; a read of the slot being written sees new data
//******************************
module miss_queue_ram import replay_pkg::*; #(
  parameter int DEPTH = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic rd_en_i,
  input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
  output queue_entry_t rd_data_o,
  input  logic wr_en_i,
  input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
  input  queue_entry_t wr_data_i
);

  localparam int AW = $clog2(DEPTH);

  queue_entry_t mem [DEPTH];
  logic [AW-1:0] rd_addr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_addr_q <= '0;
    end else if (rd_en_i) begin
      rd_addr_q <= rd_addr_i;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // array read after the write edge gives write-first behaviour
  assign rd_data_o = mem[rd_addr_q];

endmodule

// ==== miss_queue/miss_queue_ctrl.sv ====
//******************************
// miss queue pointers, flush tags and replay sequencer
// drives the lane RAMs, starts the arbiter and raises skip
//******************************
module miss_queue_ctrl import replay_pkg::*; #(
  parameter int DEPTH = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic [LANES-1:0] miss_i,
  input  mem_op_t [LANES-1:0] op_i,
  input  logic except_i,
  input  logic except_thread_i,
  input  logic all_done_i,
  input  queue_entry_t [LANES-1:0] head_i,
  output logic wr_en_o,
  output logic [$clog2(DEPTH)-1:0] wr_addr_o,
  output queue_entry_t [LANES-1:0] wr_data_o,
  output logic rd_en_o,
  output logic [$clog2(DEPTH)-1:0] rd_addr_o,
  output logic start_o,
  output logic [LANES-1:0] need_o,
  output logic replay_o,
  output logic [LANES-1:0] lane_valid_o,
  output logic skip_o
);

  localparam int AW = $clog2(DEPTH);
  localparam int CW = AW + 1;

  typedef enum logic [1:0] {
    S_IDLE,
    S_READ,
    S_XLAT,
    S_EMIT
  } state_t;

  state_t state_q, state_d;
  logic [AW-1:0] wr_ptr_q, rd_ptr_q, rd_ptr_d;
  logic [CW-1:0] count_q, count_d;
  logic [LANES-1:0][DEPTH-1:0] tag_q;
  logic [LANES-1:0][DEPTH-1:0] invalid_q;
  logic [LANES-1:0] need_q;
  logic start_q, skip_q;
  logic capture, pop, full;

  assign capture = |miss_i;
  assign pop = (state_q == S_EMIT);
  assign full = (count_q == CW'(DEPTH));
  assign count_d = count_q + CW'(capture) - CW'(pop);
  assign rd_ptr_d = rd_ptr_q + AW'(pop);

  // both lanes land in the same slot
  assign wr_en_o = capture;
  assign wr_addr_o = wr_ptr_q;
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      wr_data_o[l].miss = miss_i[l];
      wr_data_o[l].op = op_i[l];
    end
  end

  // head lanes that still have to go out
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      lane_valid_o[l] = head_i[l].miss & ~invalid_q[l][rd_ptr_q];
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: if (count_q != '0) state_d = S_READ;
      S_READ: state_d = (|lane_valid_o) ? S_XLAT : S_EMIT;
      S_XLAT: if (all_done_i) state_d = S_EMIT;
      S_EMIT: state_d = (count_d != '0) ? S_READ : S_IDLE;
      default: state_d = S_IDLE;
    endcase
  end

  // head address is loaded into the RAMs on the edge that enters READ
  assign rd_en_o = (state_d == S_READ) && (state_q != S_READ);
  assign rd_addr_o = rd_ptr_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
      need_q <= '0;
      start_q <= 1'b0;
      skip_q <= 1'b0;
    end else begin
      state_q <= state_d;
      count_q <= count_d;
      rd_ptr_q <= rd_ptr_d;
      if (capture) wr_ptr_q <= wr_ptr_q + 1'b1;
      start_q <= (state_q == S_READ) && (|lane_valid_o);
      if (state_q == S_READ) need_q <= lane_valid_o;
      if (capture) begin
        skip_q <= 1'b1;
      end else if (pop && count_q == CW'(1)) begin
        skip_q <= 1'b0;
      end
    end
  end

  // thread of every stored lane, for flushes
  always_ff @(posedge clk) begin
    if (capture) begin
      for (int l = 0; l < LANES; l++) begin
        tag_q[l][wr_ptr_q] <= op_i[l].thread;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      invalid_q <= '0;
    end else begin
      if (except_i) begin
        for (int l = 0; l < LANES; l++) begin
          for (int s = 0; s < DEPTH; s++) begin
            if (tag_q[l][s] == except_thread_i) invalid_q[l][s] <= 1'b1;
          end
        end
      end
      // a lane captured during the flush is killed on the way in
      if (capture) begin
        for (int l = 0; l < LANES; l++) begin
          invalid_q[l][wr_ptr_q] <= except_i && (op_i[l].thread == except_thread_i);
        end
      end
    end
  end

  assign start_o = start_q;
  assign need_o = need_q;
  assign replay_o = pop;
  assign skip_o = skip_q;

  // upstream stalls on skip before the queue can overflow
  a_no_capture_full: assert property (@(posedge clk) disable iff (rst)
    capture |-> !full)
    else $error("capture while miss queue full");

  a_replay_nonempty: assert property (@(posedge clk) disable iff (rst)
    replay_o |-> count_q != '0)
    else $error("replay with empty miss queue");

endmodule

// ==== src/xlat_req_arbiter.sv ====
//******************************
// shares the translation request port between the lanes
// lane 0 first, one request per needed lane, held until ack
//******************************
module xlat_req_arbiter import replay_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic start_i,
  input  logic [LANES-1:0] need_i,
  input  queue_entry_t [LANES-1:0] head_i,
  input  logic xlat_ack_i,
  output logic xlat_req_o,
  output xlat_req_t xlat_o,
  output logic all_done_o
);

  logic [LANES-1:0] pending_q;
  logic [LANES-1:0] grant;
  logic [LANES-1:0] remaining;
  logic all_done_q;
  mem_op_t sel_op;

  // lowest pending lane wins
  assign grant = pending_q & (~pending_q + 1'b1);
  assign remaining = pending_q & ~grant;

  always_comb begin
    sel_op = '0;
    for (int l = 0; l < LANES; l++) begin
      if (grant[l]) sel_op = head_i[l].op;
    end
  end

  assign xlat_req_o = |pending_q;
  assign xlat_o.page = sel_op.addr[VADDR_W-1:PAGE_SHIFT];
  assign xlat_o.attr = sel_op.attr;

  always_ff @(posedge clk) begin
    if (rst) begin
      pending_q <= '0;
      all_done_q <= 1'b0;
    end else begin
      all_done_q <= 1'b0;
      if (start_i) begin
        pending_q <= need_i;
      end else if (xlat_req_o && xlat_ack_i) begin
        pending_q <= remaining;
        // last lane acknowledged, release the sequencer
        if (remaining == '0) all_done_q <= 1'b1;
      end
    end
  end

  assign all_done_o = all_done_q;

  // page and attr must not move under an outstanding request
  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    (xlat_req_o && !xlat_ack_i) |=> (xlat_req_o && $stable(xlat_o)))
    else $error("translation request changed before ack");

endmodule

// ==== src/replay_output_mux.sv ====
//******************************
// lane output select between pass-through and replayed head
// enable of a replayed lane needs its miss flag and no flush
//******************************
module replay_output_mux import replay_pkg::*; (
  input  logic replay_i,
  input  logic [LANES-1:0] lane_valid_i,
  input  queue_entry_t [LANES-1:0] head_i,
  input  logic except_i,
  input  logic [LANES-1:0] en_i,
  input  mem_op_t [LANES-1:0] op_i,
  output logic [LANES-1:0] en_o,
  output mem_op_t [LANES-1:0] op_o
);

  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      if (replay_i) begin
        op_o[l] = head_i[l].op;
        // an exception this cycle kills the whole replay
        en_o[l] = lane_valid_i[l] & ~except_i;
      end else begin
        op_o[l] = op_i[l];
        en_o[l] = en_i[l];
      end
    end
  end

endmodule

// ==== src/tlb_miss_replay.sv ====
//******************************
// miss replay buffer for the two-lane load/store pipeline
// queues missed ops, translates them and replays them in order
//******************************
module tlb_miss_replay import replay_pkg::*; #(
  parameter int DEPTH = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic except_i,
  input  logic except_thread_i,
  input  logic [LANES-1:0] en_i,
  input  logic [LANES-1:0] miss_i,
  input  mem_op_t [LANES-1:0] op_i,
  input  logic xlat_ack_i,
  output logic [LANES-1:0] en_o,
  output mem_op_t [LANES-1:0] op_o,
  output logic skip_o,
  output logic xlat_req_o,
  output xlat_req_t xlat_o
);

  localparam int AW = $clog2(DEPTH);

  logic wr_en;
  logic [AW-1:0] wr_addr;
  queue_entry_t [LANES-1:0] wr_data;
  logic rd_en;
  logic [AW-1:0] rd_addr;
  wire queue_entry_t [LANES-1:0] head;
  logic start;
  logic [LANES-1:0] need;
  logic all_done;
  logic replay;
  logic [LANES-1:0] lane_valid;

  miss_queue_ctrl #(
    .DEPTH(DEPTH)
  ) u_ctrl (
    .clk(clk),
    .rst(rst),
    .miss_i(miss_i),
    .op_i(op_i),
    .except_i(except_i),
    .except_thread_i(except_thread_i),
    .all_done_i(all_done),
    .head_i(head),
    .wr_en_o(wr_en),
    .wr_addr_o(wr_addr),
    .wr_data_o(wr_data),
    .rd_en_o(rd_en),
    .rd_addr_o(rd_addr),
    .start_o(start),
    .need_o(need),
    .replay_o(replay),
    .lane_valid_o(lane_valid),
    .skip_o(skip_o)
  );

  miss_queue_ram #(
    .DEPTH(DEPTH)
  ) u_ram_lane0 (
    .clk(clk),
    .rst(rst),
    .rd_en_i(rd_en),
    .rd_addr_i(rd_addr),
    .rd_data_o(head[0]),
    .wr_en_i(wr_en),
    .wr_addr_i(wr_addr),
    .wr_data_i(wr_data[0])
  );

  miss_queue_ram #(
    .DEPTH(DEPTH)
  ) u_ram_lane1 (
    .clk(clk),
    .rst(rst),
    .rd_en_i(rd_en),
    .rd_addr_i(rd_addr),
    .rd_data_o(head[1]),
    .wr_en_i(wr_en),
    .wr_addr_i(wr_addr),
    .wr_data_i(wr_data[1])
  );

  xlat_req_arbiter u_arb (
    .clk(clk),
    .rst(rst),
    .start_i(start),
    .need_i(need),
    .head_i(head),
    .xlat_ack_i(xlat_ack_i),
    .xlat_req_o(xlat_req_o),
    .xlat_o(xlat_o),
    .all_done_o(all_done)
  );

  replay_output_mux u_mux (
    .replay_i(replay),
    .lane_valid_i(lane_valid),
    .head_i(head),
    .except_i(except_i),
    .en_i(en_i),
    .op_i(op_i),
    .en_o(en_o),
    .op_o(op_o)
  );

endmodule

// ==== verification/tb_tlb_miss_replay.sv ====
//******************************
// testbench for the miss replay buffer
// LFSR bursts of captures, random ack delays and thread flushes
//******************************
module tb_tlb_miss_replay import replay_pkg::*; ();

  localparam int DEPTH = 4;
  localparam int BURSTS = 40;
  localparam int MAXS = 256;
  localparam int TIMEOUT = 4000;

  logic clk;
  logic rst;
  logic except_i;
  logic except_thread_i;
  logic [LANES-1:0] en_i;
  logic [LANES-1:0] miss_i;
  mem_op_t [LANES-1:0] op_i;
  logic xlat_ack_i;
  logic [LANES-1:0] en_o;
  mem_op_t [LANES-1:0] op_o;
  logic skip_o;
  logic xlat_req_o;
  xlat_req_t xlat_o;

  // reference queue by absolute slot number
  mem_op_t [LANES-1:0] m_op [MAXS];
  logic [LANES-1:0] m_left [MAXS];
  logic [LANES-1:0] m_en [MAXS];
  int hd;
  int tl;
  logic captured;

  // first slot that still has a request or a visible replay
  int cur;
  logic live;
  logic [LANES-1:0] cur_left;
  logic [LANES-1:0] cur_en;
  mem_op_t [LANES-1:0] cur_op;
  logic [PAGE_W-1:0] exp_page;
  logic [ATTR_W-1:0] exp_attr;

  logic [31:0] lfsr;
  logic slow;
  int ack_wait;
  int ack_delay;
  int cycle_cnt;

  tlb_miss_replay #(
    .DEPTH(DEPTH)
  ) u_dut (
    .clk(clk),
    .rst(rst),
    .except_i(except_i),
    .except_thread_i(except_thread_i),
    .en_i(en_i),
    .miss_i(miss_i),
    .op_i(op_i),
    .xlat_ack_i(xlat_ack_i),
    .en_o(en_o),
    .op_o(op_o),
    .skip_o(skip_o),
    .xlat_req_o(xlat_req_o),
    .xlat_o(xlat_o)
  );

  always #4 clk = ~clk;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[62:0], lfsr[0]};
    end
  endtask

  task automatic random_op(output mem_op_t op);
    logic [63:0] r;
    take_bits(1, r);
    op.thread = r[0];
    take_bits(VADDR_W, r);
    op.addr = r[VADDR_W-1:0];
    take_bits(SZ_W, r);
    op.sz = r[SZ_W-1:0];
    take_bits(ATTR_W, r);
    op.attr = r[ATTR_W-1:0];
    take_bits(LSQ_W, r);
    op.lsq = r[LSQ_W-1:0];
    take_bits(WQ_W, r);
    op.wq = r[WQ_W-1:0];
  endtask

  // one clock edge, then ack and flush for the coming cycle
  task automatic step_cycle();
    logic [63:0] r;
    @(posedge clk);
    if (xlat_ack_i) begin
      xlat_ack_i <= 1'b0;
      take_bits(2, r);
      ack_delay = slow ? 3 : int'(r[1:0]);
      ack_wait = 0;
    end else if (xlat_req_o) begin
      if (ack_wait >= ack_delay) begin
        xlat_ack_i <= 1'b1;
      end else begin
        ack_wait++;
      end
    end
    // flush only while a request is outstanding, so later slots are not read yet
    if (xlat_req_o && !xlat_ack_i) begin
      take_bits(3, r);
      if (r[2:0] == 3'd0) begin
        except_i <= 1'b1;
        take_bits(1, r);
        except_thread_i <= r[0];
      end else begin
        except_i <= 1'b0;
      end
    end else begin
      except_i <= 1'b0;
    end
  endtask

  always_comb begin
    cur = tl;
    live = 1'b0;
    for (int s = 0; s < MAXS; s++) begin
      if (!live && s >= hd && s < tl && (m_left[s] != '0 || m_en[s] != '0)) begin
        cur = s;
        live = 1'b1;
      end
    end
    cur_left = live ? m_left[cur] : '0;
    cur_en = live ? m_en[cur] : '0;
    cur_op = live ? m_op[cur] : '0;
    if (cur_left[0]) begin
      exp_page = cur_op[0].addr[VADDR_W-1:PAGE_SHIFT];
      exp_attr = cur_op[0].attr;
    end else begin
      exp_page = cur_op[1].addr[VADDR_W-1:PAGE_SHIFT];
      exp_attr = cur_op[1].attr;
    end
  end

  // reference model update
  always @(posedge clk) begin
    if (rst) begin
      hd <= 0;
      tl <= 0;
      captured <= 1'b0;
    end else begin
      if (xlat_req_o && xlat_ack_i && live) begin
        if (cur_left[0]) begin
          m_left[cur][0] <= 1'b0;
        end else begin
          m_left[cur][1] <= 1'b0;
        end
      end
      if (skip_o && en_o != '0) hd <= cur + 1;
      if (except_i) begin
        for (int s = hd; s < tl; s++) begin
          for (int l = 0; l < LANES; l++) begin
            if (m_op[s][l].thread == except_thread_i) begin
              m_en[s][l] <= 1'b0;
              // the slot under translation already has its requests fixed
              if (s > cur) m_left[s][l] <= 1'b0;
            end
          end
        end
      end
      if (miss_i != '0) begin
        captured <= 1'b1;
        m_op[tl] <= op_i;
        for (int l = 0; l < LANES; l++) begin
          m_en[tl][l] <= miss_i[l] && !(except_i && op_i[l].thread == except_thread_i);
          m_left[tl][l] <= miss_i[l] && !(except_i && op_i[l].thread == except_thread_i);
        end
        tl <= tl + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) fail_run("timeout: the run did not finish in time");
  end

  // also sampled while reset is high
  a_reset_quiet: assert property (@(posedge clk)
    !captured |-> (!skip_o && !xlat_req_o && en_o == '0))
    else fail_run($sformatf("[ERROR] %0t: outputs active before first capture", $time));

  a_pass_through: assert property (@(posedge clk) disable iff (rst)
    !skip_o |-> (op_o == op_i && en_o == en_i))
    else fail_run($sformatf("[ERROR] %0t: pass-through mismatch", $time));

  a_req_payload: assert property (@(posedge clk) disable iff (rst)
    xlat_req_o |-> (live && cur_left != '0 && xlat_o.page == exp_page
                    && xlat_o.attr == exp_attr))
    else fail_run($sformatf("[ERROR] %0t: unexpected translation request %h",
                            $time, xlat_o));

  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    (xlat_req_o && !xlat_ack_i) |=> xlat_req_o)
    else fail_run($sformatf("[ERROR] %0t: request dropped before ack", $time));

  a_replay_slot: assert property (@(posedge clk) disable iff (rst)
    (skip_o && en_o != '0) |-> (live && cur_left == '0 && en_o == cur_en
                                && op_o == cur_op))
    else fail_run($sformatf("[ERROR] %0t: replay mismatch, en %b expected %b",
                            $time, en_o, cur_en));

  a_drained: assert property (@(posedge clk) disable iff (rst)
    $fell(skip_o) |-> !live)
    else fail_run($sformatf("[ERROR] %0t: skip fell with slots left to replay", $time));

  initial begin
    logic [63:0] r;
    mem_op_t op0;
    mem_op_t op1;
    int n;
    clk = 1'b0;
    rst = 1'b1;
    except_i = 1'b0;
    except_thread_i = 1'b0;
    en_i = '0;
    miss_i = '0;
    op_i = '0;
    xlat_ack_i = 1'b0;
    lfsr = 32'hc67c;
    slow = 1'b0;
    ack_wait = 0;
    ack_delay = 0;
    cycle_cnt = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (int b = 0; b < BURSTS; b++) begin
      // every fourth burst fills the queue under slow acks
      slow = (b % 4 == 3);
      take_bits(2, r);
      n = int'(r[1:0]) + 1;
      for (int i = 0; i < n; i++) begin
        step_cycle();
        random_op(op0);
        random_op(op1);
        take_bits(2, r);
        op_i <= {op1, op0};
        en_i <= captured ? r[1:0] : 2'b00;
        miss_i <= '0;
      end
      take_bits(2, r);
      n = slow ? 4 : int'(r[1:0]) + 1;
      for (int i = 0; i < n; i++) begin
        step_cycle();
        random_op(op0);
        random_op(op1);
        take_bits(2, r);
        op_i <= {op1, op0};
        en_i <= '0;
        miss_i <= (r[1:0] == 2'b00) ? 2'b01 : r[1:0];
      end
      step_cycle();
      miss_i <= '0;
      en_i <= '0;
      do begin
        step_cycle();
      end while (skip_o);
    end
    step_cycle();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== filelist.f ====
common/replay_pkg.sv
miss_queue/miss_queue_ram.sv
miss_queue/miss_queue_ctrl.sv
src/xlat_req_arbiter.sv
src/replay_output_mux.sv
src/tlb_miss_replay.sv
verification/tb_tlb_miss_replay.sv
